// File: hdl/irda_pkg.sv
`default_nettype none

package irda_pkg;

	localparam int IRDA_FIFO_DEPTH = 16;
	localparam int IRDA_PTR_W = 4;
	localparam int IRDA_COUNT_W = IRDA_PTR_W + 1;
	localparam logic [IRDA_COUNT_W-1:0] IRDA_FULL_COUNT = IRDA_COUNT_W'(IRDA_FIFO_DEPTH);

	localparam int SIR_DIV = 4;                       // Clocks per sample tick
	localparam int SIR_DIV_W = $clog2(SIR_DIV);
	localparam logic [SIR_DIV_W-1:0] SIR_DIV_LAST = SIR_DIV_W'(SIR_DIV - 1);

	localparam int SIR_TICKS_PER_BIT = 16;
	localparam int SIR_TICK_W = $clog2(SIR_TICKS_PER_BIT);
	localparam logic [SIR_TICK_W-1:0] SIR_TICK_LAST = SIR_TICK_W'(SIR_TICKS_PER_BIT - 1);

	localparam int SIR_PULSE_TICKS = 3;               // 3/16 of a bit
	localparam int SIR_PULSE_W = $clog2(SIR_PULSE_TICKS + 1);
	localparam logic [SIR_PULSE_W-1:0] SIR_PULSE_LOAD = SIR_PULSE_W'(SIR_PULSE_TICKS);

	localparam int SIR_FRAME_BITS = 10;               // Start, eight data bits, stop
	localparam int SIR_BIT_W = $clog2(SIR_FRAME_BITS);
	localparam logic [SIR_BIT_W-1:0] SIR_BIT_LAST = SIR_BIT_W'(SIR_FRAME_BITS - 1);

	localparam int SIR_CLKS_PER_BIT = SIR_DIV * SIR_TICKS_PER_BIT;
	localparam int SIR_WIN_W = $clog2(SIR_CLKS_PER_BIT);
	localparam logic [SIR_WIN_W-1:0] SIR_WIN_LAST = SIR_WIN_W'(SIR_CLKS_PER_BIT - 1);
	localparam logic [SIR_WIN_W-1:0] SIR_WIN_HALF = SIR_WIN_W'(SIR_CLKS_PER_BIT / 2);

	localparam logic [1:0] REG_DATA = 2'd0;
	localparam logic [1:0] REG_STATUS = 2'd1;
	localparam logic [1:0] REG_CTRL = 2'd2;

	localparam int CTRL_TX_CLEAR = 0;
	localparam int CTRL_RX_CLEAR = 1;
	localparam int CTRL_ERR_CLEAR = 2;

	typedef struct packed {
		logic       stb;
		logic       we;
		logic [1:0] addr;
		logic [7:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic       frame_err;                        // Pulse seen in the stop window
		logic [7:0] data;
	} rx_entry_t;

	typedef struct packed {
		logic                    spare;
		logic                    tx_busy;
		logic                    frame_seen_err;
		logic                    rx_underrun;
		logic                    rx_overrun;
		logic                    tx_overrun;
		logic [IRDA_COUNT_W-1:0] rx_count;
		logic [IRDA_COUNT_W-1:0] tx_count;
	} irda_status_t;

endpackage

`default_nettype wire

// File: hdl/irda_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module irda_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input  wire logic                               clk,
	input  wire logic                               wb_rst_i,
	input  wire logic                               clear_i,    // Acts like reset
	input  wire logic                               add_i,
	input  wire logic                               remove_i,
	input  wire payload_t                           dat_i,
	output payload_t                                dat_o,
	output logic                                    overrun_o,
	output logic                                    underrun_o,
	output logic [irda_pkg::IRDA_COUNT_W-1:0]       count_o
);

	payload_t mem [irda_pkg::IRDA_FIFO_DEPTH];
	logic [irda_pkg::IRDA_PTR_W-1:0] add_pos;
	logic [irda_pkg::IRDA_PTR_W-1:0] remove_pos;
	logic full;
	logic empty;
	logic wr_en;

	assign full = (count_o == irda_pkg::IRDA_FULL_COUNT);
	assign empty = (count_o == '0);
	assign wr_en = add_i && !clear_i && (remove_i || !full); // Add and remove together always write

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[add_pos] <= dat_i;
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			overrun_o <= 1'b0;
			underrun_o <= 1'b0;
			count_o <= '0;
			add_pos <= '0;
			remove_pos <= '0;
		end else if (clear_i) begin
			overrun_o <= 1'b0;
			underrun_o <= 1'b0;
			count_o <= '0;
			add_pos <= '0;
			remove_pos <= '0;
		end else begin
			overrun_o <= 1'b0;                          // Error outputs are single-cycle pulses
			underrun_o <= 1'b0;
			case ({add_i, remove_i})
				2'b01: begin
					if (empty) begin
						underrun_o <= 1'b1;
					end else begin
						remove_pos <= remove_pos + 1'b1;
						count_o <= count_o - 1'b1;
					end
				end
				2'b10: begin
					if (full) begin
						overrun_o <= 1'b1;              // The new word is dropped
					end else begin
						add_pos <= add_pos + 1'b1;
						count_o <= count_o + 1'b1;
					end
				end
				2'b11: begin
					add_pos <= add_pos + 1'b1;          // Count stays the same
					remove_pos <= remove_pos + 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	// The head falls through, so a remove consumes the word that is visible now
	assign dat_o = mem[remove_pos];

endmodule

`default_nettype wire

// File: hdl/irda_regs.sv
`timescale 1ns/1ps
`default_nettype none

module irda_regs (
	input  wire logic                               clk,
	input  wire logic                               wb_rst_i,
	input  wire irda_pkg::bus_req_t                 bus_req_i,
	input  wire logic [irda_pkg::IRDA_COUNT_W-1:0]  tx_count_i,
	input  wire logic [irda_pkg::IRDA_COUNT_W-1:0]  rx_count_i,
	input  wire logic                               tx_overrun_i,
	input  wire logic                               rx_overrun_i,
	input  wire logic                               rx_underrun_i,
	input  wire irda_pkg::rx_entry_t                rx_head_i,
	input  wire logic                               tx_busy_i,
	output logic                                    tx_add_o,
	output logic [7:0]                              tx_dat_o,
	output logic                                    rx_remove_o,
	output logic                                    tx_clear_o,
	output logic                                    rx_clear_o,
	output logic [15:0]                             rdata_o
);

	logic wr_stb;
	logic rd_stb;
	logic ctrl_wr;
	logic err_clear;
	logic tx_overrun_q;
	logic rx_overrun_q;
	logic rx_underrun_q;
	logic frame_seen_q;
	irda_pkg::irda_status_t status;

	assign wr_stb = bus_req_i.stb && bus_req_i.we;
	assign rd_stb = bus_req_i.stb && !bus_req_i.we;
	assign ctrl_wr = wr_stb && (bus_req_i.addr == irda_pkg::REG_CTRL);

	assign tx_add_o = wr_stb && (bus_req_i.addr == irda_pkg::REG_DATA); // Same-cycle push
	assign tx_dat_o = bus_req_i.wdata;
	assign rx_remove_o = rd_stb && (bus_req_i.addr == irda_pkg::REG_DATA);

	assign tx_clear_o = ctrl_wr && bus_req_i.wdata[irda_pkg::CTRL_TX_CLEAR];
	assign rx_clear_o = ctrl_wr && bus_req_i.wdata[irda_pkg::CTRL_RX_CLEAR];
	assign err_clear = ctrl_wr && bus_req_i.wdata[irda_pkg::CTRL_ERR_CLEAR];

	assign status = '{
		spare:          1'b0,
		tx_busy:        tx_busy_i,
		frame_seen_err: frame_seen_q,
		rx_underrun:    rx_underrun_q,
		rx_overrun:     rx_overrun_q,
		tx_overrun:     tx_overrun_q,
		rx_count:       rx_count_i,
		tx_count:       tx_count_i
	};

	// Sticky flags, a new error in the clearing cycle still wins
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			tx_overrun_q <= 1'b0;
			rx_overrun_q <= 1'b0;
			rx_underrun_q <= 1'b0;
			frame_seen_q <= 1'b0;
		end else begin
			if (err_clear) begin
				tx_overrun_q <= 1'b0;
				rx_overrun_q <= 1'b0;
				rx_underrun_q <= 1'b0;
				frame_seen_q <= 1'b0;
			end
			if (tx_overrun_i) begin
				tx_overrun_q <= 1'b1;
			end
			if (rx_overrun_i) begin
				rx_overrun_q <= 1'b1;
			end
			if (rx_underrun_i) begin
				rx_underrun_q <= 1'b1;
			end
			if (rx_remove_o && (rx_count_i != '0) && rx_head_i.frame_err) begin
				frame_seen_q <= 1'b1;                   // Only a real entry counts
			end
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			rdata_o <= '0;
		end else if (rd_stb) begin
			case (bus_req_i.addr)
				irda_pkg::REG_DATA:   rdata_o <= {7'b0, rx_head_i}; // Stale if the FIFO is empty
				irda_pkg::REG_STATUS: rdata_o <= status;
				default:              rdata_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/irda_sir_tx.sv
`timescale 1ns/1ps
`default_nettype none

module irda_sir_tx (
	input  wire logic                               clk,
	input  wire logic                               wb_rst_i,
	input  wire logic [irda_pkg::IRDA_COUNT_W-1:0]  tx_count_i,
	input  wire logic [7:0]                         tx_head_i,
	output logic                                    tx_remove_o,
	output logic                                    tx_busy_o,
	output logic                                    ir_tx_o
);

	logic busy_q;
	logic [irda_pkg::SIR_DIV_W-1:0] div_cnt;
	logic [irda_pkg::SIR_TICK_W-1:0] tick_cnt;
	logic [irda_pkg::SIR_BIT_W-1:0] bit_cnt;
	logic [irda_pkg::SIR_PULSE_W-1:0] pulse_cnt;
	logic [irda_pkg::SIR_FRAME_BITS-1:0] shift_q;
	logic tick;
	logic bit_end;

	assign tx_remove_o = !busy_q && (tx_count_i != '0);  // Head is valid, FIFO falls through
	assign tick = busy_q && (div_cnt == irda_pkg::SIR_DIV_LAST);
	assign bit_end = tick && (tick_cnt == irda_pkg::SIR_TICK_LAST);
	assign tx_busy_o = busy_q;
	assign ir_tx_o = (pulse_cnt != '0);

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			busy_q <= 1'b0;
			div_cnt <= '0;
			tick_cnt <= '0;
			bit_cnt <= '0;
			pulse_cnt <= '0;
		end else if (tx_remove_o) begin
			busy_q <= 1'b1;
			div_cnt <= '0;                              // Windows start at the pop
			tick_cnt <= '0;
			bit_cnt <= '0;
			pulse_cnt <= irda_pkg::SIR_PULSE_LOAD;      // Start bit is a zero
		end else if (busy_q) begin
			if (tick) begin
				div_cnt <= '0;
				tick_cnt <= tick_cnt + 1'b1;
				if (pulse_cnt != '0) begin
					pulse_cnt <= pulse_cnt - 1'b1;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			if (bit_end) begin
				tick_cnt <= '0;
				if (bit_cnt == irda_pkg::SIR_BIT_LAST) begin
					busy_q <= 1'b0;                     // Stop bit done
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					pulse_cnt <= shift_q[1] ? '0 : irda_pkg::SIR_PULSE_LOAD;
				end
			end
		end
	end

	// Frame is start, data LSB first, then stop, bit 0 is on the air
	always_ff @(posedge clk) begin
		if (tx_remove_o) begin
			shift_q <= {1'b1, tx_head_i, 1'b0};
		end else if (bit_end) begin
			shift_q <= {1'b1, shift_q[irda_pkg::SIR_FRAME_BITS-1:1]};
		end
	end

endmodule

`default_nettype wire

// File: hdl/irda_sir_rx.sv
`timescale 1ns/1ps
`default_nettype none

module irda_sir_rx (
	input  wire logic             clk,
	input  wire logic             wb_rst_i,
	input  wire logic             ir_rx_i,
	output logic                  rx_add_o,
	output irda_pkg::rx_entry_t   rx_entry_o
);

	logic [1:0] sync_q;
	logic prev_q;
	logic rise;
	logic active_q;
	logic [irda_pkg::SIR_WIN_W-1:0] win_cnt;
	logic [irda_pkg::SIR_BIT_W-1:0] bit_idx;
	logic pulse_q;
	logic pulse_now;
	logic win_end;
	logic last_win;
	logic [7:0] data_q;

	assign rise = sync_q[1] && !prev_q;
	assign pulse_now = pulse_q || rise;                 // A pulse in the last cycle still counts
	assign win_end = active_q && (win_cnt == irda_pkg::SIR_WIN_LAST);
	assign last_win = (bit_idx == irda_pkg::SIR_BIT_LAST);

	// Windows are shifted by half a bit so that each expected pulse sits mid-window
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			sync_q <= '0;
			prev_q <= 1'b0;
			active_q <= 1'b0;
			win_cnt <= '0;
			bit_idx <= '0;
			pulse_q <= 1'b0;
			rx_add_o <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], ir_rx_i};
			prev_q <= sync_q[1];
			rx_add_o <= 1'b0;
			if (!active_q) begin
				if (rise) begin
					active_q <= 1'b1;                   // Start pulse found
					win_cnt <= irda_pkg::SIR_WIN_HALF;
					bit_idx <= '0;
					pulse_q <= 1'b0;
				end
			end else begin
				if (rise) begin
					pulse_q <= 1'b1;
				end
				if (win_end) begin
					win_cnt <= '0;
					pulse_q <= 1'b0;
					bit_idx <= bit_idx + 1'b1;
					if (last_win) begin
						active_q <= 1'b0;
						rx_add_o <= 1'b1;               // One-cycle push into the receive FIFO
					end
				end else begin
					win_cnt <= win_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (win_end) begin
			if (last_win) begin
				rx_entry_o <= '{frame_err: pulse_now, data: data_q};
			end else if (bit_idx != '0) begin
				data_q <= {!pulse_now, data_q[7:1]};    // Pulse means zero, LSB arrives first
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/irda_top.sv
`timescale 1ns/1ps
`default_nettype none

module irda_top (
	input  wire logic                 clk,
	input  wire logic                 wb_rst_i,
	input  wire irda_pkg::bus_req_t   bus_req_i,
	input  wire logic                 ir_rx_i,
	output logic [15:0]               rdata_o,
	output logic                      ir_tx_o
);

	logic tx_add;
	logic tx_remove;
	logic tx_clear;
	logic tx_overrun;
	logic tx_busy;
	logic [7:0] tx_dat;
	logic [7:0] tx_head;
	logic [irda_pkg::IRDA_COUNT_W-1:0] tx_count;
	logic rx_add;
	logic rx_remove;
	logic rx_clear;
	logic rx_overrun;
	logic rx_underrun;
	logic [irda_pkg::IRDA_COUNT_W-1:0] rx_count;
	irda_pkg::rx_entry_t rx_entry;
	irda_pkg::rx_entry_t rx_head;

	irda_regs regs (
		.clk           (clk),
		.wb_rst_i      (wb_rst_i),
		.bus_req_i     (bus_req_i),
		.tx_count_i    (tx_count),
		.rx_count_i    (rx_count),
		.tx_overrun_i  (tx_overrun),
		.rx_overrun_i  (rx_overrun),
		.rx_underrun_i (rx_underrun),
		.rx_head_i     (rx_head),
		.tx_busy_i     (tx_busy),
		.tx_add_o      (tx_add),
		.tx_dat_o      (tx_dat),
		.rx_remove_o   (rx_remove),
		.tx_clear_o    (tx_clear),
		.rx_clear_o    (rx_clear),
		.rdata_o       (rdata_o)
	);

	irda_fifo #(.payload_t(logic [7:0])) tx_fifo (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.clear_i    (tx_clear),
		.add_i      (tx_add),
		.remove_i   (tx_remove),
		.dat_i      (tx_dat),
		.dat_o      (tx_head),
		.overrun_o  (tx_overrun),
		.underrun_o (),                                 // Encoder never pops an empty FIFO
		.count_o    (tx_count)
	);

	irda_fifo #(.payload_t(irda_pkg::rx_entry_t)) rx_fifo (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.clear_i    (rx_clear),
		.add_i      (rx_add),
		.remove_i   (rx_remove),
		.dat_i      (rx_entry),
		.dat_o      (rx_head),
		.overrun_o  (rx_overrun),
		.underrun_o (rx_underrun),
		.count_o    (rx_count)
	);

	irda_sir_tx sir_tx (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.tx_count_i  (tx_count),
		.tx_head_i   (tx_head),
		.tx_remove_o (tx_remove),
		.tx_busy_o   (tx_busy),
		.ir_tx_o     (ir_tx_o)
	);

	irda_sir_rx sir_rx (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.ir_rx_i    (ir_rx_i),
		.rx_add_o   (rx_add),
		.rx_entry_o (rx_entry)
	);

endmodule

`default_nettype wire

// File: test/irda_tb_tasks.svh
// Every task starts and ends 2 ns after a rising edge, so bus requests can run back to back

task automatic idle_cycles(input int cycles);
	repeat (cycles) @(posedge clk);
	#DRIVE_DELAY;
endtask

task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
	bus_req = '{stb: 1'b1, we: 1'b1, addr: addr, wdata: data};
	@(posedge clk);
	#DRIVE_DELAY;
	bus_req = '0;
endtask

task automatic bus_read(input logic [1:0] addr, output logic [15:0] data);
	bus_req = '{stb: 1'b1, we: 1'b0, addr: addr, wdata: 8'h00};
	@(posedge clk);
	#DRIVE_DELAY;
	bus_req = '0;
	data = rdata;                                       // Registered at the edge that took the strobe
endtask

task automatic wait_status(input irda_pkg::irda_status_t mask, input irda_pkg::irda_status_t want,
		input int limit, input string what);
	logic [15:0] word;
	int polls;
	polls = 0;
	bus_read(irda_pkg::REG_STATUS, word);
	while (((word & mask) != want) && (polls < limit)) begin
		bus_read(irda_pkg::REG_STATUS, word);
		polls++;
	end
	assert ((word & mask) == want) else
		stop_on_error($sformatf("Timeout while waiting for %s after %0d status reads", what, polls));
endtask

// Drives one frame with a short pulse for every zero bit
task automatic send_frame(input logic [7:0] value, input logic bad_stop);
	logic [9:0] bits;
	int i;
	bits = {~bad_stop, value, 1'b0};
	for (i = 0; i < 10; i++) begin
		ir_gen = !bits[i];
		repeat (PULSE_CLKS) @(posedge clk);
		#DRIVE_DELAY;
		ir_gen = 1'b0;
		repeat (BIT_CLKS - PULSE_CLKS) @(posedge clk);
		#DRIVE_DELAY;
	end
endtask

// File: test/irda_tb.sv
`timescale 1ns/1ps
`default_nettype none

module irda_tb;

	localparam int CLK_HALF = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int PULSE_CLKS = irda_pkg::SIR_PULSE_TICKS * irda_pkg::SIR_DIV;
	localparam int BIT_CLKS = irda_pkg::SIR_TICKS_PER_BIT * irda_pkg::SIR_DIV;
	localparam int FRAME_CLKS = 10 * BIT_CLKS;          // Start, eight data bits, stop
	localparam int NUM_LOOP = 5;

	logic clk;
	logic wb_rst_i;
	irda_pkg::bus_req_t bus_req;
	logic loopback;                                     // High feeds the encoder back into the decoder
	logic ir_gen;
	logic ir_rx;
	logic ir_tx;
	logic [15:0] rdata;

	assign ir_rx = loopback ? ir_tx : ir_gen;

	irda_top UUT (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.bus_req_i (bus_req),
		.ir_rx_i   (ir_rx),
		.rdata_o   (rdata),
		.ir_tx_o   (ir_tx)
	);

	always #CLK_HALF clk = ~clk;

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else
			stop_on_error($sformatf("Mismatch %s: expected 0x%04h, got 0x%04h", name, exp, got));
	endtask

	// Data register layout is the frame error flag above the byte
	function automatic logic [15:0] data_word(input logic frame_err, input logic [7:0] value);
		return {7'b0, frame_err, value};
	endfunction

	`include "irda_tb_tasks.svh"

	initial begin
		logic [7:0] sent [NUM_LOOP];
		logic [7:0] value;
		logic [15:0] word;
		irda_pkg::irda_status_t mask;
		irda_pkg::irda_status_t want;
		int i;

		clk = 1'b0;
		wb_rst_i = 1'b1;
		bus_req = '0;
		loopback = 1'b1;
		ir_gen = 1'b0;
		void'($urandom(93));
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		wb_rst_i = 1'b0;

		// 1. Quiet after reset
		check_value("rdata_o", rdata, 16'h0000);
		bus_read(irda_pkg::REG_STATUS, word);
		check_value("status", word, 16'h0000);
		for (i = 0; i < BIT_CLKS; i++) begin
			check_value("ir_tx_o", 16'(ir_tx), 16'h0000);
			idle_cycles(1);
		end

		// 2. Loopback through the encoder and the decoder
		for (i = 0; i < NUM_LOOP; i++) begin
			sent[i] = 8'($urandom);
			bus_write(irda_pkg::REG_DATA, sent[i]);
		end
		mask = '0;
		mask.rx_count = '1;
		want = '0;
		want.rx_count = 5'(NUM_LOOP);
		wait_status(mask, want, 2 * NUM_LOOP * FRAME_CLKS, "five loopback frames");
		for (i = 0; i < NUM_LOOP; i++) begin
			bus_read(irda_pkg::REG_DATA, word);
			check_value("rx data", word, data_word(1'b0, sent[i]));
		end
		mask = '0;
		mask.tx_busy = 1'b1;
		want = '0;
		wait_status(mask, want, FRAME_CLKS, "the encoder to go idle");
		bus_read(irda_pkg::REG_STATUS, word);
		check_value("status", word, 16'h0000);

		// 3. Transmit overrun, the first byte is popped and one more than fits is dropped
		loopback = 1'b0;
		bus_write(irda_pkg::REG_CTRL, 8'(1 << irda_pkg::CTRL_TX_CLEAR));
		wait_status(mask, want, FRAME_CLKS, "the encoder to go idle");
		for (i = 0; i < irda_pkg::IRDA_FIFO_DEPTH + 2; i++) begin
			bus_write(irda_pkg::REG_DATA, 8'($urandom));
		end
		mask = '0;
		mask.tx_overrun = 1'b1;
		wait_status(mask, mask, 8, "tx_overrun");
		want = '0;
		want.tx_count = 5'(irda_pkg::IRDA_FIFO_DEPTH);
		want.tx_overrun = 1'b1;
		want.tx_busy = 1'b1;
		bus_read(irda_pkg::REG_STATUS, word);
		check_value("status", word, want);
		bus_write(irda_pkg::REG_CTRL, 8'(1 << irda_pkg::CTRL_ERR_CLEAR));
		bus_read(irda_pkg::REG_STATUS, word);
		want.tx_overrun = 1'b0;
		check_value("status", word, want);
		bus_write(irda_pkg::REG_CTRL, 8'(1 << irda_pkg::CTRL_TX_CLEAR));

		// 4. Receive underrun on an empty FIFO
		mask = '0;
		mask.tx_busy = 1'b1;
		want = '0;
		wait_status(mask, want, FRAME_CLKS, "the encoder to go idle");
		bus_read(irda_pkg::REG_DATA, word);
		mask = '0;
		mask.rx_underrun = 1'b1;
		wait_status(mask, mask, 8, "rx_underrun");
		bus_read(irda_pkg::REG_STATUS, word);
		check_value("status", word, mask);
		bus_write(irda_pkg::REG_CTRL, 8'(1 << irda_pkg::CTRL_ERR_CLEAR));

		// 5. Pulse in the stop window
		value = 8'($urandom);
		send_frame(value, 1'b1);
		mask = '0;
		mask.rx_count = '1;
		want = '0;
		want.rx_count = 5'd1;
		wait_status(mask, want, BIT_CLKS, "the framed entry");
		bus_read(irda_pkg::REG_DATA, word);
		check_value("rx data", word, data_word(1'b1, value));
		want = '0;
		want.frame_seen_err = 1'b1;
		bus_read(irda_pkg::REG_STATUS, word);
		check_value("status", word, want);
		bus_write(irda_pkg::REG_CTRL, 8'(1 << irda_pkg::CTRL_ERR_CLEAR));

		// 6. Both clears empty their FIFOs
		send_frame(value, 1'b0);
		send_frame(~value, 1'b0);
		want = '0;
		want.rx_count = 5'd2;
		wait_status(mask, want, BIT_CLKS, "two received entries");
		for (i = 0; i < 3; i++) begin
			bus_write(irda_pkg::REG_DATA, 8'($urandom));
		end
		want.tx_count = 5'd2;                           // The first byte went to the encoder
		want.tx_busy = 1'b1;
		bus_read(irda_pkg::REG_STATUS, word);
		check_value("status", word, want);
		bus_write(irda_pkg::REG_CTRL,
			8'((1 << irda_pkg::CTRL_TX_CLEAR) | (1 << irda_pkg::CTRL_RX_CLEAR)));
		want.tx_count = 5'd0;
		want.rx_count = 5'd0;
		bus_read(irda_pkg::REG_STATUS, word);
		check_value("status", word, want);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+test
hdl/irda_pkg.sv
hdl/irda_fifo.sv
hdl/irda_regs.sv
hdl/irda_sir_tx.sv
hdl/irda_sir_rx.sv
hdl/irda_top.sv
test/irda_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module irda_tb -f project.f -o irda_sim \
	|| { echo "Verilator build failed"; exit 1; }

output="$(./obj_dir/irda_sim 2>&1)"
echo "$output"

echo "$output" | grep -q "^Simulation finished: PASS$" && exit 0 || exit 1
